//--- hdl/trg_config.svh
`ifndef TRG_CONFIG_SVH
`define TRG_CONFIG_SVH

// number of ADC channels
`define TRG_NUM_CH 2

// data converter beat, 16-bit slots
`define TRG_TDATA_W 128

// ADC resolution in bits
`define TRG_ADC_W 12

// time stamp width
`define TRG_TIME_W 48

// beats kept after the hit ends
`define TRG_POST_LEN 6
// longest trigger window in beats
`define TRG_ACQUI_LEN 16

// hit record buffer entries
`define TRG_FIFO_DEPTH 4

`endif

//--- hdl/trg_pkg.sv
`include "trg_config.svh"

package trg_pkg;

  // one ADC sample and its threshold, one bit wider for the delta range
  typedef logic signed [`TRG_ADC_W-1:0] sample_t;
  typedef logic signed [`TRG_ADC_W:0]   thresh_t;

  typedef logic [`TRG_TDATA_W-1:0] beat_t;

  typedef logic [$clog2(`TRG_NUM_CH)-1:0] ch_idx_t;

  // captured at hit start
  typedef struct packed {
    logic [`TRG_TIME_W-1:0] time_stamp;
    sample_t                baseline;
    thresh_t                threshold;
  } hit_info_t;

  // buffer entry
  typedef struct packed {
    hit_info_t info;
    ch_idx_t   ch;
  } hit_rec_t;

  // per channel setup
  typedef struct packed {
    sample_t baseline;
    thresh_t threshold;
  } ch_cfg_t;

endpackage

//--- hdl/channel_trigger.sv
`include "trg_config.svh"

module channel_trigger
  import trg_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RESETN,
  input  beat_t                  tdata,
  input  logic                   tvalid,
  input  ch_cfg_t                cfg,
  input  logic [`TRG_TIME_W-1:0] current_time,
  input  logic                   all_ready,
  output beat_t                  data,
  output logic                   valid,
  output logic                   triggered,
  output logic                   rec_stb,
  output hit_info_t              rec
);

  localparam int SLOT_W   = 16;
  localparam int NUM_SLOT = `TRG_TDATA_W / SLOT_W;
  localparam int POST_W   = $clog2(`TRG_POST_LEN + 1);
  localparam int ACQ_W    = $clog2(`TRG_ACQUI_LEN + 1);

  beat_t               tdata_q;
  beat_t               dly1;
  beat_t               dly2;
  beat_t               data_d;
  logic [2:0]          vld_pipe;
  logic [NUM_SLOT-1:0] cmp;
  logic [NUM_SLOT-1:0] cmp_d;
  logic                hit;
  logic                hit_next;
  logic                hit_rise;
  logic                hit_fall;
  hit_info_t           info_q;
  logic                finalize;
  logic                over_len;
  logic [POST_W-1:0]   post_cnt;
  logic [ACQ_W-1:0]    acq_cnt;

  // valid follows the beat through input, compare and hit stages
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[1:0], tvalid};
    end
  end

  always_ff @(posedge CLK) begin
    tdata_q <= tdata;
    dly1    <= tdata_q;
    dly2    <= dly1;
    // time and setup seen at the compare edge
    info_q.time_stamp <= current_time;
    info_q.baseline   <= cfg.baseline;
    info_q.threshold  <= cfg.threshold;
  end

  // every slot must clear baseline + threshold
  always_comb begin
    sample_t smp;
    thresh_t delta;
    for (int i = 0; i < NUM_SLOT; i++) begin
      smp      = tdata_q[i*SLOT_W +: `TRG_ADC_W];
      delta    = smp - cfg.baseline;
      cmp_d[i] = (delta >= cfg.threshold);
    end
  end

  assign hit_next = &cmp;
  assign hit_rise = hit_next & ~hit;
  assign hit_fall = hit & ~hit_next;

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      cmp     <= '0;
      hit     <= 1'b0;
      rec_stb <= 1'b0;
    end else begin
      cmp     <= vld_pipe[0] ? cmp_d : '0;
      hit     <= hit_next;
      rec_stb <= hit_rise;
    end
  end

  always_ff @(posedge CLK) begin
    if (hit_rise) begin
      rec <= info_q;
    end
  end

  // post-hit tail, counts from the hit end
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      finalize <= 1'b0;
      post_cnt <= '0;
    end else if (hit_rise) begin
      finalize <= 1'b0;
    end else if (hit_fall) begin
      finalize <= 1'b1;
      post_cnt <= POST_W'(1);
    end else if (finalize) begin
      if (post_cnt == POST_W'(`TRG_POST_LEN)) begin
        finalize <= 1'b0;
      end else begin
        post_cnt <= post_cnt + 1'b1;
      end
    end
  end

  // window length limit, counts from the hit start and saturates
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      acq_cnt  <= '0;
      over_len <= 1'b0;
    end else if (hit_rise) begin
      acq_cnt  <= ACQ_W'(1);
      over_len <= 1'b0;
    end else if (acq_cnt == ACQ_W'(`TRG_ACQUI_LEN)) begin
      over_len <= 1'b1;
    end else begin
      acq_cnt <= acq_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      triggered <= 1'b0;
      valid     <= 1'b0;
    end else begin
      triggered <= (hit | finalize) & ~over_len & all_ready & vld_pipe[2];
      valid     <= vld_pipe[2];
    end
  end

  // 12-bit samples zero-extended in place
  always_comb begin
    for (int i = 0; i < NUM_SLOT; i++) begin
      data_d[i*SLOT_W +: SLOT_W] = {{(SLOT_W-`TRG_ADC_W){1'b0}}, dly2[i*SLOT_W +: `TRG_ADC_W]};
    end
  end

  always_ff @(posedge CLK) begin
    data <= vld_pipe[2] ? data_d : '1;
  end

  a_rec_stb_single: assert property (@(posedge CLK) disable iff (!RESETN)
    rec_stb |=> !rec_stb);

  a_trig_valid: assert property (@(posedge CLK) disable iff (!RESETN)
    triggered |-> valid);

endmodule

//--- hdl/record_arbiter.sv
`include "trg_config.svh"

module record_arbiter
  import trg_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RESETN,
  input  logic [`TRG_NUM_CH-1:0] rec_stb,
  input  hit_info_t              rec [`TRG_NUM_CH],
  output logic                   wr_stb,
  output hit_rec_t               wr_rec
);

  localparam int N = `TRG_NUM_CH;

  logic [N-1:0] pend;
  logic [N-1:0] grant;
  hit_info_t    copy [N];
  ch_idx_t      ptr;
  ch_idx_t      sel;

  // first pending channel at or after the pointer
  always_comb begin : pick
    int   idx;
    logic found;
    grant = '0;
    sel   = '0;
    found = 1'b0;
    for (int off = 0; off < N; off++) begin
      idx = (int'(ptr) + off) % N;
      if (!found && pend[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        sel        = ch_idx_t'(idx);
      end
    end
  end

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      pend   <= '0;
      ptr    <= '0;
      wr_stb <= 1'b0;
    end else begin
      // a new strobe wins over the grant of the same channel
      pend   <= (pend & ~grant) | rec_stb;
      wr_stb <= |grant;
      if (|grant) begin
        ptr <= (int'(sel) == N - 1) ? '0 : sel + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < N; i++) begin
      if (rec_stb[i]) begin
        copy[i] <= rec[i];
      end
    end
    if (|grant) begin
      wr_rec.info <= copy[sel];
      wr_rec.ch   <= sel;
    end
  end

  a_one_grant: assert property (@(posedge CLK) disable iff (!RESETN)
    $onehot0(grant));

endmodule

//--- hdl/record_fifo.sv
`include "trg_config.svh"

module record_fifo
  import trg_pkg::*;
(
  input  logic     CLK,
  input  logic     RESETN,
  input  logic     wr_stb,
  input  hit_rec_t wr_rec,
  input  logic     rd_stb,
  output hit_rec_t rd_data,
  output logic     empty,
  output logic     overflow
);

  localparam int DEPTH = `TRG_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  hit_rec_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));
  assign do_rd = rd_stb & ~empty;
  // a pop frees the slot for a write on the same edge
  assign do_wr = wr_stb & (~full | do_rd);

  assign rd_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_rec;
    end
  end

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
      // sticky until reset
      overflow <= overflow | (wr_stb & ~do_wr);
    end
  end

  a_count_bound: assert property (@(posedge CLK) disable iff (!RESETN)
    count <= CW'(DEPTH));

endmodule

//--- hdl/trigger_top.sv
`include "trg_config.svh"

module trigger_top
  import trg_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RESETN,
  input  beat_t                  tdata [`TRG_NUM_CH],
  input  logic [`TRG_NUM_CH-1:0] tvalid,
  input  ch_cfg_t                cfg [`TRG_NUM_CH],
  input  logic [`TRG_TIME_W-1:0] current_time,
  input  logic                   all_ready,
  input  logic                   rd_stb,
  output beat_t                  data [`TRG_NUM_CH],
  output logic [`TRG_NUM_CH-1:0] valid,
  output logic [`TRG_NUM_CH-1:0] triggered,
  output hit_rec_t               rd_data,
  output logic                   empty,
  output logic                   overflow
);

  logic [`TRG_NUM_CH-1:0] rec_stb;
  hit_info_t              rec [`TRG_NUM_CH];
  logic                   wr_stb;
  hit_rec_t               wr_rec;

  // one trigger per ADC channel
  for (genvar g = 0; g < `TRG_NUM_CH; g++) begin : g_ch
    channel_trigger u_ch (
      .CLK          (CLK),
      .RESETN       (RESETN),
      .tdata        (tdata[g]),
      .tvalid       (tvalid[g]),
      .cfg          (cfg[g]),
      .current_time (current_time),
      .all_ready    (all_ready),
      .data         (data[g]),
      .valid        (valid[g]),
      .triggered    (triggered[g]),
      .rec_stb      (rec_stb[g]),
      .rec          (rec[g])
    );
  end

  record_arbiter u_arb (
    .CLK    (CLK),
    .RESETN (RESETN),
    .rec_stb(rec_stb),
    .rec    (rec),
    .wr_stb (wr_stb),
    .wr_rec (wr_rec)
  );

  record_fifo u_fifo (
    .CLK     (CLK),
    .RESETN  (RESETN),
    .wr_stb  (wr_stb),
    .wr_rec  (wr_rec),
    .rd_stb  (rd_stb),
    .rd_data (rd_data),
    .empty   (empty),
    .overflow(overflow)
  );

endmodule

//--- sim/tb_trigger_top.sv
`include "trg_config.svh"

module tb_trigger_top
  import trg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NCH   = `TRG_NUM_CH;
  localparam int          NSLOT = `TRG_TDATA_W / 16;
  localparam int          NCOL  = 10;
  localparam int          NTEST = 10;
  localparam int          TAIL  = 24;
  localparam int          LIMIT = 200;
  localparam logic [31:0] SEED  = 32'ha3662033;
  localparam beat_t       SLOT_MASK = {NSLOT{16'h0fff}};

  logic                   CLK = 1'b0;
  logic                   RESETN;
  beat_t                  tdata [NCH];
  logic [NCH-1:0]         tvalid;
  ch_cfg_t                cfg [NCH];
  logic [`TRG_TIME_W-1:0] current_time;
  logic                   all_ready;
  logic                   rd_stb;
  beat_t                  data [NCH];
  logic [NCH-1:0]         valid;
  logic [NCH-1:0]         triggered;
  hit_rec_t               rd_data;
  logic                   empty;
  logic                   overflow;

  logic [15:0]            pat [NTEST*NCOL];
  logic [31:0]            lfsr;
  logic [`TRG_TIME_W-1:0] cyc = '0;
  logic [`TRG_TIME_W-1:0] drive_cyc;
  beat_t                  hb [4][NCH];
  logic                   hv [4][NCH];
  int                     hist_n;
  int                     trig_cnt [NCH];
  int                     trig_runs [NCH];
  logic [NCH-1:0]         trig_q;
  hit_rec_t               exp_q [$];
  int                     rr_next;
  string                  tname;
  int                     t_ch;
  sample_t                t_base;
  thresh_t                t_thr;
  sample_t                t_lvl;
  int                     t_hits;
  int                     t_start;
  int                     t_len;
  int                     t_mode;
  int                     t_nhit;

  trigger_top dut0 (.*);

  always #5 CLK = ~CLK;

  // time base counts rising edges and reaches the DUT on the falling one
  always @(posedge CLK) begin
    cyc <= cyc + 1'b1;
  end

  always @(negedge CLK) begin
    current_time <= cyc;
  end

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_beat(input string what, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      $display("** Error: %s %s expected %h actual %h", tname, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_rec(input string what, input hit_rec_t exp, input hit_rec_t act);
    if (act !== exp) begin
      $display("** Error: %s %s expected %h actual %h", tname, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_len(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("** Error: %s %s expected %0d actual %0d", tname, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input bit exp, input bit act);
    if (act != exp) begin
      $display("** Error: %s %s expected %0b actual %0b", tname, what, exp, act);
      abort_run();
    end
  endtask

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // upper n_hit slots at the hit level and the rest at baseline plus noise
  task automatic make_beat(input int n_hit, output beat_t b);
    logic [7:0] r;
    sample_t    smp;
    for (int i = 0; i < NSLOT; i++) begin
      for (int j = 0; j < 8; j++) begin
        r = {r[6:0], lfsr_bit()};
      end
      smp = (i >= NSLOT - n_hit) ? t_lvl : t_base + sample_t'(r[3:0]);
      // junk in the upper nibble for the DUT to clear
      b[i*16 +: 16] = {r[7:4], smp};
    end
  endtask

  // check outputs settled since the rising edge and then drive one cycle of inputs
  task automatic step(input logic [NCH-1:0] hm, input logic [NCH-1:0] v, input logic rd);
    beat_t b;
    @(negedge CLK);
    drive_cyc = cyc;
    for (int c = 0; c < NCH; c++) begin
      if (hist_n >= 4) begin
        check_flag("valid", hv[3][c], valid[c]);
        check_beat("data", hv[3][c] ? (hb[3][c] & SLOT_MASK) : '1, data[c]);
      end
      if (triggered[c] && !trig_q[c]) begin
        trig_runs[c]++;
      end
      if (triggered[c]) begin
        trig_cnt[c]++;
      end
      trig_q[c] = triggered[c];
      for (int k = 3; k > 0; k--) begin
        hb[k][c] = hb[k-1][c];
        hv[k][c] = hv[k-1][c];
      end
      make_beat(hm[c] ? t_nhit : 0, b);
      hb[0][c] = b;
      hv[0][c] = v[c];
      tdata[c] = b;
    end
    tvalid = v;
    rd_stb = rd;
    hist_n++;
  endtask

  task automatic apply_reset();
    RESETN  = 1'b0;
    hist_n  = 0;
    rr_next = 0;
    repeat (10) step('0, '0, 1'b0);
    RESETN = 1'b1;
  endtask

  // background beats and hit beats on the channels in hm followed by a tail for the window
  task automatic fire_hit(input logic [NCH-1:0] hm);
    int c;
    int first;
    trig_cnt  = '{default: 0};
    trig_runs = '{default: 0};
    for (int k = 0; k < t_start + t_hits + TAIL; k++) begin
      step((k >= t_start && k < t_start + t_hits) ? hm : '0, '1, 1'b0);
      if (k == t_start && t_mode != 1) begin
        // round robin starts past the last channel served
        first = rr_next;
        for (int i = 0; i < NCH; i++) begin
          c = (first + i) % NCH;
          if (hm[c]) begin
            rr_next = (c + 1) % NCH;
            // records past the buffer depth are lost
            if (exp_q.size() < `TRG_FIFO_DEPTH) begin
              exp_q.push_back({drive_cyc + 1'b1, t_base, t_thr, ch_idx_t'(c)});
            end
          end
        end
      end
    end
    for (int i = 0; i < NCH; i++) begin
      check_len("trigger cycles", hm[i] ? t_len : 0, trig_cnt[i]);
      check_len("trigger runs", (hm[i] && t_len > 0) ? 1 : 0, trig_runs[i]);
    end
  endtask

  task automatic wait_record();
    int n;
    n = 0;
    while (empty) begin
      step('0, '0, 1'b0);
      n++;
      if (n >= LIMIT) begin
        $display("timeout: no hit record reached the buffer within %0d cycles", LIMIT);
        abort_run();
      end
    end
  endtask

  task automatic run_test(input int t);
    int             reps;
    logic [NCH-1:0] hm;
    hit_rec_t       exp;
    tname   = $sformatf("test %0d", pat[t*NCOL]);
    t_ch    = pat[t*NCOL+1];
    t_base  = pat[t*NCOL+2][11:0];
    t_thr   = pat[t*NCOL+3][12:0];
    t_lvl   = pat[t*NCOL+4][11:0];
    t_hits  = pat[t*NCOL+5];
    t_start = pat[t*NCOL+6];
    t_len   = pat[t*NCOL+8];
    t_mode  = pat[t*NCOL+9];
    t_nhit  = (t_mode == 1) ? NSLOT - 1 : NSLOT;
    if (t_mode >= 2) begin
      apply_reset();
    end
    for (int c = 0; c < NCH; c++) begin
      cfg[c] = '{baseline: t_base, threshold: t_thr};
    end
    all_ready = pat[t*NCOL+7][0];
    hm   = (t_mode == 2) ? '1 : NCH'(1) << t_ch;
    reps = (t_mode == 3) ? 6 : (t_mode == 2) ? 2 : 1;
    repeat (reps) fire_hit(hm);
    // invalid gap where data reads all ones
    repeat (4) step('0, '0, 1'b0);
    check_flag("empty", exp_q.size() == 0, empty);
    check_flag("overflow", t_mode == 3, overflow);
    while (exp_q.size() > 0) begin
      wait_record();
      exp = exp_q.pop_front();
      check_rec("record", exp, rd_data);
      step('0, '0, 1'b1);
      step('0, '0, 1'b0);
    end
    check_flag("empty after reads", 1'b1, empty);
  endtask

  initial begin
    RESETN       = 1'b0;
    tvalid       = '0;
    rd_stb       = 1'b0;
    all_ready    = 1'b0;
    current_time = '0;
    lfsr         = SEED;
    trig_q       = '0;
    t_base       = '0;
    t_lvl        = '0;
    for (int c = 0; c < NCH; c++) begin
      tdata[c] = '0;
      cfg[c]   = '0;
    end
    $readmemh("sim/trigger_patterns.txt", pat);
    apply_reset();
    for (int t = 0; t < NTEST; t++) begin
      run_test(t);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+hdl
hdl/trg_pkg.sv
hdl/channel_trigger.sv
hdl/record_arbiter.sv
hdl/record_fifo.sv
hdl/trigger_top.sv
sim/tb_trigger_top.sv

//--- sim/trigger_patterns.txt
// test ch baseline threshold level hits start ready length mode, all hex
// mode 0 single hit, 1 one slot stays low, 2 both channels twice, 3 six hits unread
// short, medium and long hits
01 0 0100 0040 0180 02 04 1 08 0
02 1 0f9c 0030 0000 05 03 1 0b 0
03 0 0200 0080 0300 0e 05 1 10 0
// no hit, no record
04 1 0050 0020 00a0 03 04 1 00 1
// ready low, record only
05 0 0080 0040 0100 03 04 0 00 0
// single beat hit
06 1 0100 0040 0140 01 02 1 07 0
07 0 0f00 0010 0f20 02 06 1 08 0
// delta exactly at the threshold
08 1 0300 0100 0400 04 02 1 0a 0
// arbitration after reset
09 0 0010 0020 0040 02 03 1 08 2
// buffer overflow
0a 1 0100 0040 0180 02 03 1 08 3
